// ==== Bender.yml ====
package:
  name: kf_core

sources:
  - files:
      - verilog/kf_fixed_pkg.sv
      - verilog/kf_model_pkg.sv
      - verilog/kf_matmul.sv
      - verilog/kf_inv2x2.sv
      - verilog/kf_control.sv
      - verilog/kf_top.sv
  - target: simulation
    files:
      - dv/kf_clk_gen.sv
      - dv/kf_chk.sv
      - dv/kf_tb.sv

// ==== dv/kf_chk.sv ====
`timescale 1ns/100ps

module kf_chk (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     start,
    input logic                     init,
    input logic                     done,
    input kf_model_pkg::state_vec_t x_filt,
    input kf_model_pkg::state_mat_t p_filt
);
    int   err_cnt = 0;  // Failed assertions so far
    logic idle_q;       // Core idle and outputs held

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idle_q <= 1'b1;                   // Outputs hold from reset as well
        end else if (start) begin
            idle_q <= 1'b0;
        end else if (done) begin
            idle_q <= 1'b1;
        end
    end

    // --------------------
    // Pulse protocol
    // --------------------
    a_reset_done: assert property (@(posedge clk) !rst_n |-> !done)
        else begin
            err_cnt++;
            $error("done is high while in reset");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            err_cnt++;
            $error("done stayed high for two cycles");
        end

    // Init command gives done exactly three cycles after start
    a_init_lat: assert property (@(posedge clk) disable iff (!rst_n)
        start && init && idle_q |=> !done ##1 !done ##1 done)
        else begin
            err_cnt++;
            $error("done did not follow an init start after 3 cycles");
        end

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        done || idle_q |=> $stable(x_filt) && $stable(p_filt))
        else begin
            err_cnt++;
            $error("x_filt or p_filt changed while the core was idle");
        end

endmodule

// ==== dv/kf_clk_gen.sv ====
`timescale 1ns/100ps

module kf_clk_gen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD  = 10;   // 20 ns clock
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset held low, released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== dv/kf_tb.sv ====
`timescale 1ns/100ps

module kf_tb;
    import kf_fixed_pkg::*;
    import kf_model_pkg::*;

    // --------------------
    // Run length
    // --------------------
    localparam int RECIP_CYCLES = DATA_WIDTH + FRAC_BITS;   // Reciprocal iterations
    localparam int N_CHAIN      = 8;                         // Chained updates
    localparam int N_CMDS       = 8 + N_CHAIN;               // All init and update commands
    localparam int CLK_NS       = 20;
    localparam int TIMEOUT_NS   = 2 * (N_CMDS * (RECIP_CYCLES + 20) + 10) * CLK_NS;

    logic        clk, rst_n;
    logic        start, init, done;
    meas_vec_t   z;
    state_mat_t  f_mat, q_mat, p_init, p_filt;
    obs_mat_t    h_mat;
    meas_mat_t   r_mat;
    state_vec_t  x_init, x_filt;
    logic [15:0] lfsr_q = 16'd11127;   // Seed

    kf_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    kf_top DUT (
        .clk(clk), .rst_n(rst_n), .start(start), .init(init),
        .z(z), .f_mat(f_mat), .q_mat(q_mat), .h_mat(h_mat), .r_mat(r_mat),
        .x_init(x_init), .p_init(p_init),
        .done(done), .x_filt(x_filt), .p_filt(p_filt)
    );

    bind kf_top kf_chk u_chk (
        .clk(clk), .rst_n(rst_n), .start(start), .init(init),
        .done(done), .x_filt(x_filt), .p_filt(p_filt)
    );

    // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Value in [-64, 64) with one LFSR step per bit
    function automatic fp_t rand_fp();
        logic [22:0] bits;
        for (int b = 0; b < 23; b++) begin
            lfsr_q  = lfsr_step(lfsr_q);
            bits[b] = lfsr_q[0];
        end
        return fp_t'(signed'(bits));
    endfunction

    task automatic fail_stop(input string why);
        $display(">>> FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_fp(input fp_t got, input fp_t exp, input string what);
        assert (got == exp) else begin
            $display("CHECK FAILED at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            fail_stop("value mismatch");
        end
    endtask

    task automatic check_state(input state_vec_t x_exp);
        for (int i = 0; i < STATE_DIM; i++) begin
            check_fp(x_filt[i], x_exp[i], $sformatf("x_filt[%0d]", i));
        end
    endtask

    task automatic check_cov(input state_mat_t p_exp);
        for (int i = 0; i < STATE_DIM; i++) begin
            for (int j = 0; j < STATE_DIM; j++) begin
                check_fp(p_filt[i][j], p_exp[i][j], $sformatf("p_filt[%0d][%0d]", i, j));
            end
        end
    endtask

    // Tracker model with F = I, Q = 0, P = I, R = I and H picking x and y
    task automatic load_defaults();
        state_mat_t eye;
        obs_mat_t   hsel;
        meas_mat_t  reye;
        eye  = '0;
        hsel = '0;
        reye = '0;
        for (int i = 0; i < STATE_DIM; i++) begin
            eye[i][i] = FP_ONE;
        end
        hsel[0][0] = FP_ONE;    // Position x
        hsel[1][1] = FP_ONE;    // Position y
        reye[0][0] = FP_ONE;
        reye[1][1] = FP_ONE;
        f_mat  <= eye;
        q_mat  <= '0;
        p_init <= eye;
        h_mat  <= hsel;
        r_mat  <= reye;
    endtask

    // Start pulse and wait for done
    task automatic run_cmd(input logic with_init);
        @(posedge clk);
        start <= 1'b1;
        init  <= with_init;
        @(posedge clk);
        start <= 1'b0;
        init  <= 1'b0;
        while (done !== 1'b1) begin
            @(posedge clk);
        end
    endtask

    // --------------------
    // Scenarios
    // --------------------
    initial begin
        state_vec_t xr, x_exp;
        state_mat_t pr;
        meas_vec_t  zr;
        longint     p_sel, s_sel, det, recip, s_inv, k_sel;   // Scalar filter per axis
        start  <= 1'b0;
        init   <= 1'b0;
        z      <= '0;
        f_mat  <= '0;
        q_mat  <= '0;
        h_mat  <= '0;
        r_mat  <= '0;
        x_init <= '0;
        p_init <= '0;
        @(posedge rst_n);
        @(posedge clk);

        // Init load with a fully random covariance
        for (int i = 0; i < STATE_DIM; i++) begin
            xr[i] = rand_fp();
            for (int j = 0; j < STATE_DIM; j++) begin
                pr[i][j] = rand_fp();
            end
        end
        load_defaults();
        x_init <= xr;
        p_init <= pr;           // Overrides the default
        run_cmd(1'b1);
        check_state(xr);
        check_cov(pr);

        // Single update with gain one half on x and y
        for (int i = 0; i < STATE_DIM; i++) begin
            xr[i] = rand_fp();
        end
        zr[0] = rand_fp();
        zr[1] = rand_fp();
        load_defaults();
        x_init <= xr;
        z      <= zr;
        run_cmd(1'b1);
        run_cmd(1'b0);
        x_exp = xr;
        for (int a = 0; a < MEAS_DIM; a++) begin
            x_exp[a] = fp_t'((longint'(xr[a]) + longint'(zr[a])) >>> 1);   // Mean rounded down
        end
        check_state(x_exp);
        pr = '0;
        pr[0][0] = FP_ONE >>> 1;
        pr[1][1] = FP_ONE >>> 1;
        pr[2][2] = FP_ONE;
        pr[3][3] = FP_ONE;
        check_cov(pr);

        // Constant velocity with H zero and no correction
        for (int i = 0; i < STATE_DIM; i++) begin
            xr[i] = rand_fp();
        end
        pr = '0;
        for (int i = 0; i < STATE_DIM; i++) begin
            pr[i][i] = FP_ONE;
        end
        pr[0][2] = FP_ONE;      // x += vx
        pr[1][3] = FP_ONE;      // y += vy
        load_defaults();
        f_mat  <= pr;
        h_mat  <= '0;
        x_init <= xr;
        run_cmd(1'b1);
        run_cmd(1'b0);
        x_exp    = xr;
        x_exp[0] = xr[0] + xr[2];
        x_exp[1] = xr[1] + xr[3];
        check_state(x_exp);
        check_fp(p_filt[0][0], FP_ONE + FP_ONE, "p_filt[0][0]");   // F P F' with P = I

        // Singular S where the regularized inverse gives zero gain
        for (int i = 0; i < STATE_DIM; i++) begin
            xr[i] = rand_fp();
        end
        zr[0] = rand_fp();
        zr[1] = rand_fp();
        load_defaults();
        h_mat  <= '0;
        r_mat  <= '0;
        x_init <= xr;
        z      <= zr;
        run_cmd(1'b1);
        run_cmd(1'b0);
        check_state(xr);        // With F = I the state is the prediction

        // Chained updates on the default model
        for (int i = 0; i < STATE_DIM; i++) begin
            xr[i] = rand_fp();
        end
        load_defaults();
        x_init <= xr;
        run_cmd(1'b1);
        x_exp = xr;
        p_sel = longint'(FP_ONE);
        for (int n = 0; n < N_CHAIN; n++) begin
            zr[0] = rand_fp();
            zr[1] = rand_fp();
            z <= zr;
            run_cmd(1'b0);
            s_sel = p_sel + longint'(FP_ONE);                      // S = P + R
            det   = (s_sel * s_sel) >>> FRAC_BITS;                  // Both axes alike
            recip = (longint'(1) << (2 * FRAC_BITS)) / det;
            s_inv = (s_sel * recip) >>> FRAC_BITS;                  // Adjugate times 1/det
            k_sel = (p_sel * s_inv) >>> FRAC_BITS;                  // K = P S^-1
            for (int a = 0; a < MEAS_DIM; a++) begin
                x_exp[a] = fp_t'(longint'(x_exp[a])
                         + ((k_sel * (longint'(zr[a]) - longint'(x_exp[a]))) >>> FRAC_BITS));
            end
            p_sel = ((longint'(FP_ONE) - k_sel) * p_sel) >>> FRAC_BITS;   // 1 / (1 + 1/P)
            check_state(x_exp);
            pr = '0;
            pr[0][0] = fp_t'(p_sel);
            pr[1][1] = fp_t'(p_sel);
            pr[2][2] = FP_ONE;
            pr[3][3] = FP_ONE;
            check_cov(pr);
        end

        repeat (4) @(posedge clk);   // Let the last protocol checks settle
        if (DUT.u_chk.err_cnt == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("A protocol assertion in kf_chk failed");
            fail_stop("protocol check");
        end
    end

    // Protocol failures stop the run at once
    initial begin
        wait (DUT.u_chk.err_cnt != 0);
        $display("A protocol assertion in kf_chk failed");
        fail_stop("protocol check");
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        fail_stop("watchdog expired");
    end

endmodule

// ==== list.f ====
verilog/kf_fixed_pkg.sv
verilog/kf_model_pkg.sv
verilog/kf_matmul.sv
verilog/kf_inv2x2.sv
verilog/kf_control.sv
verilog/kf_top.sv
dv/kf_clk_gen.sv
dv/kf_chk.sv
dv/kf_tb.sv

// ==== verilog/kf_control.sv ====
`timescale 1ns/100ps

module kf_control (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic                     init,
    input  kf_model_pkg::meas_vec_t  z,
    input  kf_model_pkg::state_mat_t f_mat,
    input  kf_model_pkg::state_mat_t q_mat,
    input  kf_model_pkg::obs_mat_t   h_mat,
    input  kf_model_pkg::meas_mat_t  r_mat,
    input  kf_model_pkg::state_vec_t x_init,
    input  kf_model_pkg::state_mat_t p_init,
    output logic                     done,
    output kf_model_pkg::state_vec_t x_filt,
    output kf_model_pkg::state_mat_t p_filt,
    output logic                     mm_start,
    output kf_model_pkg::state_mat_t mm_a,
    output kf_model_pkg::state_mat_t mm_b,
    input  kf_model_pkg::state_mat_t mm_c,
    input  logic                     mm_done,
    output logic                     inv_start,
    output kf_model_pkg::meas_mat_t  s_mat,
    input  kf_model_pkg::meas_mat_t  s_inv,
    input  logic                     inv_done
);
    import kf_fixed_pkg::*;
    import kf_model_pkg::*;

    kf_phase_e  phase;

    // Filter state
    state_vec_t x_reg;
    state_mat_t p_reg;

    // Per-step intermediates
    state_vec_t xp_reg;     // Predicted state
    state_mat_t pp_reg;     // Predicted covariance
    meas_vec_t  y_reg;      // Innovation
    gain_mat_t  k_reg;      // Kalman gain

    // Next values, one per step
    state_vec_t xp_next, x_next;
    state_mat_t pp_next, p_next;
    meas_vec_t  y_next;
    meas_mat_t  s_next;
    gain_mat_t  k_next;
    obs_mat_t   hpp;        // H Pp
    gain_mat_t  pph;        // Pp H'
    state_mat_t ikh;        // I - K H

    assign mm_a = f_mat;    // F P formed by the multiplier
    assign mm_b = p_reg;

    // --------------------
    // Predict
    // --------------------
    always_comb begin
        fp_t acc;
        for (int i = 0; i < STATE_DIM; i++) begin
            acc = FP_ZERO;
            for (int j = 0; j < STATE_DIM; j++) begin
                acc = acc + fp_mul(f_mat[i][j], x_reg[j]);
            end
            xp_next[i] = acc;
            for (int j = 0; j < STATE_DIM; j++) begin
                acc = q_mat[i][j];
                for (int k = 0; k < STATE_DIM; k++) begin
                    acc = acc + fp_mul(mm_c[i][k], f_mat[j][k]);   // (F P) F'
                end
                pp_next[i][j] = acc;
            end
        end
    end

    // --------------------
    // Innovation and S
    // --------------------
    always_comb begin
        fp_t acc;
        for (int i = 0; i < MEAS_DIM; i++) begin
            acc = z[i];
            for (int j = 0; j < STATE_DIM; j++) begin
                acc = acc - fp_mul(h_mat[i][j], xp_reg[j]);
            end
            y_next[i] = acc;
            for (int j = 0; j < STATE_DIM; j++) begin
                acc = FP_ZERO;
                for (int k = 0; k < STATE_DIM; k++) begin
                    acc = acc + fp_mul(h_mat[i][k], pp_reg[k][j]);
                end
                hpp[i][j] = acc;
            end
        end
        for (int i = 0; i < MEAS_DIM; i++) begin
            for (int j = 0; j < MEAS_DIM; j++) begin
                acc = r_mat[i][j];
                for (int k = 0; k < STATE_DIM; k++) begin
                    acc = acc + fp_mul(hpp[i][k], h_mat[j][k]);    // Times H'
                end
                s_next[i][j] = acc;
            end
        end
    end

    // --------------------
    // Gain and update
    // --------------------
    always_comb begin
        fp_t acc;
        for (int i = 0; i < STATE_DIM; i++) begin
            for (int j = 0; j < MEAS_DIM; j++) begin
                acc = FP_ZERO;
                for (int k = 0; k < STATE_DIM; k++) begin
                    acc = acc + fp_mul(pp_reg[i][k], h_mat[j][k]);
                end
                pph[i][j] = acc;
            end
            for (int j = 0; j < MEAS_DIM; j++) begin
                acc = FP_ZERO;
                for (int m = 0; m < MEAS_DIM; m++) begin
                    acc = acc + fp_mul(pph[i][m], s_inv[m][j]);
                end
                k_next[i][j] = acc;
            end
            acc = xp_reg[i];
            for (int j = 0; j < MEAS_DIM; j++) begin
                acc = acc + fp_mul(k_reg[i][j], y_reg[j]);
            end
            x_next[i] = acc;
            for (int j = 0; j < STATE_DIM; j++) begin
                acc = (i == j) ? FP_ONE : FP_ZERO;
                for (int m = 0; m < MEAS_DIM; m++) begin
                    acc = acc - fp_mul(k_reg[i][m], h_mat[m][j]);
                end
                ikh[i][j] = acc;
            end
        end
        // Simple form, not Joseph
        for (int i = 0; i < STATE_DIM; i++) begin
            for (int j = 0; j < STATE_DIM; j++) begin
                acc = FP_ZERO;
                for (int k = 0; k < STATE_DIM; k++) begin
                    acc = acc + fp_mul(ikh[i][k], pp_reg[k][j]);
                end
                p_next[i][j] = acc;
            end
        end
    end

    // Phase sequencer and filter state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= IDLE;
            done      <= 1'b0;
            mm_start  <= 1'b0;
            inv_start <= 1'b0;
            x_reg     <= '0;
            p_reg     <= '0;
            x_filt    <= '0;
            p_filt    <= '0;
        end else begin
            done      <= 1'b0;
            mm_start  <= 1'b0;
            inv_start <= 1'b0;
            case (phase)
                IDLE: if (start) begin
                    if (init) phase <= LOAD;
                    else      phase <= PREDICT_X;
                end
                LOAD: begin
                    x_reg  <= x_init;
                    p_reg  <= p_init;
                    x_filt <= x_init;
                    p_filt <= p_init;
                    phase  <= DONE;
                end
                PREDICT_X: begin
                    mm_start <= 1'b1;             // F P starts next cycle
                    phase    <= PREDICT_P;
                end
                PREDICT_P: if (mm_done) phase <= INNOVATE;
                INNOVATE:  phase <= INNOV_COV;
                INNOV_COV: begin
                    inv_start <= 1'b1;            // S is registered by then
                    phase     <= INVERT;
                end
                INVERT: if (inv_done) phase <= GAIN;
                GAIN:   phase <= UPDATE_X;
                UPDATE_X: begin
                    x_reg  <= x_next;
                    x_filt <= x_next;
                    phase  <= UPDATE_P;
                end
                UPDATE_P: begin
                    p_reg  <= p_next;
                    p_filt <= p_next;
                    phase  <= DONE;
                end
                DONE: begin
                    done  <= 1'b1;
                    phase <= IDLE;
                end
                default: phase <= IDLE;
            endcase
        end
    end

    // Intermediates, each written in its own phase
    always_ff @(posedge clk) begin
        case (phase)
            PREDICT_X: xp_reg <= xp_next;
            PREDICT_P: if (mm_done) pp_reg <= pp_next;
            INNOVATE:  y_reg  <= y_next;
            INNOV_COV: s_mat  <= s_next;
            GAIN:      k_reg  <= k_next;
            default: ;
        endcase
    end

endmodule

// ==== verilog/kf_fixed_pkg.sv ====
package kf_fixed_pkg;

    // --------------------
    // Number format
    // --------------------
    localparam int DATA_WIDTH = 32;                  // Bits per value
    localparam int FRAC_BITS  = 16;                  // Q15.16 layout

    // Signed scalar, two's complement
    typedef logic signed [DATA_WIDTH-1:0] fp_t;

    // Full-precision product or sum of products
    typedef logic signed [2*DATA_WIDTH-1:0] acc_t;

    // --------------------
    // Constants
    // --------------------
    localparam fp_t FP_ONE  = fp_t'(1 << FRAC_BITS); // 1.0
    localparam fp_t FP_ZERO = '0;                    // 0.0

    // --------------------
    // Arithmetic
    // --------------------
    // Product of two values, rescaled back to the value format
    // Low fraction bits are dropped, so rounding is toward minus infinity
    function automatic fp_t fp_mul(input fp_t a, input fp_t b);
        acc_t prod;
        prod = acc_t'(a) * acc_t'(b);                // Sign-extended, no overflow
        return prod[DATA_WIDTH+FRAC_BITS-1:FRAC_BITS];
    endfunction

endpackage

// ==== verilog/kf_inv2x2.sv ====
`timescale 1ns/100ps

module kf_inv2x2 (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  kf_model_pkg::meas_mat_t s_mat,
    output kf_model_pkg::meas_mat_t s_inv,
    output logic                    done
);
    import kf_fixed_pkg::*;
    import kf_model_pkg::*;

    localparam int RECIP_CYCLES = DATA_WIDTH + FRAC_BITS;   // One quotient bit per cycle
    localparam int CNT_W        = $clog2(RECIP_CYCLES);

    typedef enum logic [1:0] {
        INV_IDLE,
        INV_DIV,     // Restoring divide, 1.0 / |det|
        INV_SCALE    // Adjugate times reciprocal
    } inv_step_e;

    inv_step_e             step;
    logic [CNT_W-1:0]      cnt;        // Divide iterations left
    acc_t                  det_full;
    fp_t                   det;        // Determinant of incoming S
    logic [DATA_WIDTH-1:0] det_mag;
    meas_mat_t             s_reg;      // S captured at start
    logic                  det_neg;
    logic [DATA_WIDTH-1:0] divisor;
    logic [RECIP_CYCLES-1:0] dvd;      // Dividend, shifted out MSB first
    logic [RECIP_CYCLES-1:0] quo;      // Quotient, shifted in LSB first
    logic [DATA_WIDTH:0]   rem;        // Partial remainder, one guard bit
    logic [DATA_WIDTH:0]   rem_sh;
    fp_t                   recip;      // Signed 1/det

    // --------------------
    // Determinant
    // --------------------
    assign det_full = acc_t'(s_mat[0][0]) * acc_t'(s_mat[1][1])
                    - acc_t'(s_mat[0][1]) * acc_t'(s_mat[1][0]);
    assign det      = det_full[DATA_WIDTH+FRAC_BITS-1:FRAC_BITS];
    assign det_mag  = det[DATA_WIDTH-1] ? DATA_WIDTH'(-det) : DATA_WIDTH'(det);

    assign rem_sh = {rem[DATA_WIDTH-1:0], dvd[RECIP_CYCLES-1]};   // Bring down next bit
    assign recip  = det_neg ? -fp_t'(quo[DATA_WIDTH-1:0]) : fp_t'(quo[DATA_WIDTH-1:0]);

    // Step control and result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step  <= INV_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
            s_inv <= '0;
        end else begin
            done <= 1'b0;
            case (step)
                INV_IDLE: if (start) begin
                    cnt  <= CNT_W'(RECIP_CYCLES - 1);
                    step <= (det == FP_ZERO) ? INV_SCALE : INV_DIV;   // Singular skips divide
                end
                INV_DIV: begin
                    if (cnt == '0) step <= INV_SCALE;
                    else           cnt  <= cnt - 1'b1;
                end
                INV_SCALE: begin
                    s_inv[0][0] <= fp_mul(s_reg[1][1], recip);
                    s_inv[0][1] <= fp_mul(-s_reg[0][1], recip);
                    s_inv[1][0] <= fp_mul(-s_reg[1][0], recip);
                    s_inv[1][1] <= fp_mul(s_reg[0][0], recip);
                    done        <= 1'b1;
                    step        <= INV_IDLE;
                end
                default: step <= INV_IDLE;
            endcase
        end
    end

    // --------------------
    // Reciprocal datapath
    // --------------------
    always_ff @(posedge clk) begin
        if (step == INV_IDLE && start) begin
            s_reg   <= s_mat;
            det_neg <= det[DATA_WIDTH-1];
            divisor <= det_mag;
            rem     <= '0;
            dvd     <= RECIP_CYCLES'(FP_ONE) << FRAC_BITS;            // 1.0 at double scale
            quo     <= (det == FP_ZERO) ? RECIP_CYCLES'(FP_ONE) : '0; // Regularized to 1.0
        end else if (step == INV_DIV) begin
            dvd <= dvd << 1;
            if (rem_sh >= {1'b0, divisor}) begin
                rem <= rem_sh - {1'b0, divisor};
                quo <= {quo[RECIP_CYCLES-2:0], 1'b1};
            end else begin
                rem <= rem_sh;                                      // Restore
                quo <= {quo[RECIP_CYCLES-2:0], 1'b0};
            end
        end
    end

endmodule

// ==== verilog/kf_matmul.sv ====
`timescale 1ns/100ps

module kf_matmul (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  kf_model_pkg::state_mat_t a,
    input  kf_model_pkg::state_mat_t b,
    output kf_model_pkg::state_mat_t c,
    output logic                     done
);
    import kf_fixed_pkg::*;
    import kf_model_pkg::*;

    state_mat_t prod;   // a times b, settles within the start cycle

    // --------------------
    // Product array
    // --------------------
    always_comb begin
        fp_t acc;
        for (int i = 0; i < STATE_DIM; i++) begin
            for (int j = 0; j < STATE_DIM; j++) begin
                acc = FP_ZERO;
                for (int k = 0; k < STATE_DIM; k++) begin
                    acc = acc + fp_mul(a[i][k], b[k][j]);   // Rescaled per term
                end
                prod[i][j] = acc;
            end
        end
    end

    // Result register, held until the next start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c    <= '0;
            done <= 1'b0;
        end else begin
            done <= start;              // One cycle after start
            if (start) begin
                c <= prod;
            end
        end
    end

endmodule

// ==== verilog/kf_model_pkg.sv ====
package kf_model_pkg;

    // --------------------
    // Filter dimensions
    // --------------------
    localparam int STATE_DIM = 4;   // x, y, vx, vy
    localparam int MEAS_DIM  = 2;   // Measured x and y

    // --------------------
    // Vectors and matrices
    // --------------------
    // Matrices are indexed [row][col], rows are the outer dimension
    typedef kf_fixed_pkg::fp_t [STATE_DIM-1:0] state_vec_t;
    typedef kf_fixed_pkg::fp_t [MEAS_DIM-1:0]  meas_vec_t;

    typedef state_vec_t [STATE_DIM-1:0] state_mat_t;   // F, Q, P
    typedef meas_vec_t  [MEAS_DIM-1:0]  meas_mat_t;    // R, S, S inverse
    typedef state_vec_t [MEAS_DIM-1:0]  obs_mat_t;     // H, 2 rows by 4
    typedef meas_vec_t  [STATE_DIM-1:0] gain_mat_t;    // K, 4 rows by 2

    // --------------------
    // Sequencer phases
    // --------------------
    typedef enum logic [3:0] {
        IDLE,        // Wait for start
        LOAD,        // Take x_init and P_init
        PREDICT_X,   // xp = F x
        PREDICT_P,   // Pp = F P F' + Q
        INNOVATE,    // y = z - H xp
        INNOV_COV,   // S = H Pp H' + R
        INVERT,      // Wait for S inverse
        GAIN,        // K = Pp H' S^-1
        UPDATE_X,    // x = xp + K y
        UPDATE_P,    // P = (I - K H) Pp
        DONE         // Pulse done
    } kf_phase_e;

endpackage

// ==== verilog/kf_top.sv ====
`timescale 1ns/100ps

module kf_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic                     init,
    input  kf_model_pkg::meas_vec_t  z,
    input  kf_model_pkg::state_mat_t f_mat,
    input  kf_model_pkg::state_mat_t q_mat,
    input  kf_model_pkg::obs_mat_t   h_mat,
    input  kf_model_pkg::meas_mat_t  r_mat,
    input  kf_model_pkg::state_vec_t x_init,
    input  kf_model_pkg::state_mat_t p_init,
    output logic                     done,
    output kf_model_pkg::state_vec_t x_filt,
    output kf_model_pkg::state_mat_t p_filt
);
    import kf_model_pkg::*;

    // --------------------
    // Multiplier link
    // --------------------
    logic       mm_start, mm_done;
    state_mat_t mm_a, mm_b, mm_c;

    // Inverse link
    logic       inv_start, inv_done;
    meas_mat_t  s_mat, s_inv;

    kf_control u_control (
        .clk(clk), .rst_n(rst_n), .start(start), .init(init),
        .z(z), .f_mat(f_mat), .q_mat(q_mat), .h_mat(h_mat), .r_mat(r_mat),
        .x_init(x_init), .p_init(p_init),
        .done(done), .x_filt(x_filt), .p_filt(p_filt),
        .mm_start(mm_start), .mm_a(mm_a), .mm_b(mm_b), .mm_c(mm_c), .mm_done(mm_done),
        .inv_start(inv_start), .s_mat(s_mat), .s_inv(s_inv), .inv_done(inv_done)
    );

    kf_matmul u_matmul (
        .clk(clk), .rst_n(rst_n), .start(mm_start),
        .a(mm_a), .b(mm_b), .c(mm_c), .done(mm_done)
    );

    kf_inv2x2 u_inv (
        .clk(clk), .rst_n(rst_n), .start(inv_start),
        .s_mat(s_mat), .s_inv(s_inv), .done(inv_done)
    );

endmodule
